// ==== files.f ====
+incdir+hw
hw/debug_pkg.sv
hw/program_loader.sv
hw/state_dumper.sv
hw/debug_controller.sv
hw/debug_unit_top.sv
sim/debug_unit_checker.sv
sim/debug_unit_tb.sv

// ==== hw/debug_controller.sv ====
module debug_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_rx_valid,
    input  logic [7:0]              i_rx_byte,
    input  logic                    i_halt,
    input  logic                    i_load_done,
    input  logic                    i_dump_done,
    output debug_pkg::target_ctrl_t o_target,
    output logic                    o_load_start,
    output logic                    o_load_rx_valid,
    output logic                    o_dump_start
);

    import debug_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        stepping;  // Dump came from a step

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_rx_valid) begin
                    case (i_rx_byte)
                        CMD_RUN:  state_next = RUN;
                        CMD_STEP: state_next = STEP_WAIT;
                        CMD_LOAD: state_next = LOAD;
                        default:  state_next = IDLE;
                    endcase
                end
            end
            RUN: begin
                if (i_halt) begin
                    state_next = DUMP;
                end
            end
            STEP_WAIT: begin
                if (i_rx_valid && i_rx_byte == CMD_NEXT) begin
                    state_next = STEP_PULSE;
                end
            end
            STEP_PULSE: begin
                state_next = DUMP;  // Single enabled cycle
            end
            LOAD: begin
                if (i_load_done) begin
                    state_next = IDLE;
                end
            end
            DUMP: begin
                if (i_dump_done) begin
                    if (stepping && !i_halt) begin
                        state_next = STEP_WAIT;
                    end else begin
                        state_next = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            stepping     <= 1'b0;
            o_load_start <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            state        <= state_next;
            o_load_start <= (state == IDLE) && (state_next == LOAD);
            o_dump_start <= (state != DUMP) && (state_next == DUMP);
            if (state == STEP_PULSE) begin
                stepping <= 1'b1;
            end else if (state == RUN) begin
                stepping <= 1'b0;
            end
        end
    end

    // Target is held in reset only while idle or loading
    always_comb begin
        o_target.clk_en = (state == RUN) || (state == STEP_PULSE);
        o_target.reset  = (state == IDLE) || (state == LOAD);
    end

    assign o_load_rx_valid = i_rx_valid && (state == LOAD);

endmodule

// ==== hw/debug_params.svh ====
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// Target data path width
`define DBG_WORD_BITS       32

// Registers sent in each dump
`define DBG_REG_COUNT       32

// Data-memory words sent in each dump
`define DBG_DMEM_WORDS      16

// Instruction memory byte address width
`define DBG_IMEM_ADDR_BITS  10

`endif

// ==== hw/debug_pkg.sv ====
`include "debug_params.svh"

package debug_pkg;

    localparam logic [7:0] CMD_RUN  = 8'h72;  // 'r'
    localparam logic [7:0] CMD_STEP = 8'h73;  // 's'
    localparam logic [7:0] CMD_LOAD = 8'h6c;  // 'l'
    localparam logic [7:0] CMD_NEXT = 8'h6e;  // 'n'

    typedef struct packed {
        logic                           valid;
        logic [`DBG_IMEM_ADDR_BITS-1:0] addr;
        logic [`DBG_WORD_BITS-1:0]      data;
    } imem_write_t;

    typedef struct packed {
        logic clk_en;
        logic reset;
    } target_ctrl_t;

    typedef struct packed {
        logic [$clog2(`DBG_REG_COUNT)-1:0] reg_sel;
        logic [`DBG_WORD_BITS-1:0]         mem_addr;  // Byte address
    } state_read_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_byte_t;

    typedef enum logic [2:0] {
        IDLE,
        RUN,
        STEP_WAIT,
        STEP_PULSE,
        LOAD,
        DUMP
    } ctrl_state_e;

endpackage

// ==== hw/debug_unit_top.sv ====
`include "debug_params.svh"

module debug_unit_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_rx_valid,
    input  logic [7:0]                        i_rx_byte,
    input  logic                              i_tx_ready,
    output logic                              o_tx_valid,
    output logic [7:0]                        o_tx_byte,
    input  logic                              i_halt,
    input  logic [`DBG_WORD_BITS-1:0]         i_pc,
    input  logic [`DBG_WORD_BITS-1:0]         i_cycle_count,
    input  logic [`DBG_WORD_BITS-1:0]         i_reg_data,
    input  logic [`DBG_WORD_BITS-1:0]         i_mem_data,
    output logic [$clog2(`DBG_REG_COUNT)-1:0] o_reg_sel,
    output logic [`DBG_WORD_BITS-1:0]         o_mem_addr,
    output logic                              o_imem_wr_en,
    output logic [`DBG_IMEM_ADDR_BITS-1:0]    o_imem_addr,
    output logic [`DBG_WORD_BITS-1:0]         o_imem_data,
    output logic                              o_target_clk_en,
    output logic                              o_target_reset
);

    import debug_pkg::*;

    target_ctrl_t target;
    imem_write_t  imem_wr;
    state_read_t  state_read;
    tx_byte_t     tx;
    logic         load_start;
    logic         load_rx_valid;
    logic         load_done;
    logic         dump_start;
    logic         dump_done;

    debug_controller i_debug_controller (
        .clk             (clk),
        .reset           (reset),
        .i_rx_valid      (i_rx_valid),
        .i_rx_byte       (i_rx_byte),
        .i_halt          (i_halt),
        .i_load_done     (load_done),
        .i_dump_done     (dump_done),
        .o_target        (target),
        .o_load_start    (load_start),
        .o_load_rx_valid (load_rx_valid),
        .o_dump_start    (dump_start)
    );

    program_loader i_program_loader (
        .clk        (clk),
        .reset      (reset),
        .i_start    (load_start),
        .i_rx_valid (load_rx_valid),  // Gated by the controller
        .i_rx_byte  (i_rx_byte),
        .o_imem_wr  (imem_wr),
        .o_done     (load_done)
    );

    state_dumper i_state_dumper (
        .clk           (clk),
        .reset         (reset),
        .i_start       (dump_start),
        .i_pc          (i_pc),
        .i_cycle_count (i_cycle_count),
        .i_reg_data    (i_reg_data),
        .i_mem_data    (i_mem_data),
        .i_tx_ready    (i_tx_ready),
        .o_read        (state_read),
        .o_tx          (tx),
        .o_done        (dump_done)
    );

    assign o_tx_valid      = tx.valid;
    assign o_tx_byte       = tx.data;
    assign o_reg_sel       = state_read.reg_sel;
    assign o_mem_addr      = state_read.mem_addr;
    assign o_imem_wr_en    = imem_wr.valid;
    assign o_imem_addr     = imem_wr.addr;
    assign o_imem_data     = imem_wr.data;
    assign o_target_clk_en = target.clk_en;
    assign o_target_reset  = target.reset;

endmodule

// ==== hw/program_loader.sv ====
`include "debug_params.svh"

module program_loader (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_start,
    input  logic                   i_rx_valid,
    input  logic [7:0]             i_rx_byte,
    output debug_pkg::imem_write_t o_imem_wr,
    output logic                   o_done
);

    localparam int W = `DBG_WORD_BITS;
    localparam int AW = `DBG_IMEM_ADDR_BITS;
    localparam logic [W-1:0] END_WORD = '1;
    localparam logic [AW-1:0] ADDR_STEP = AW'(4);

    logic [1:0]    byte_cnt;
    logic [W-1:0]  word;
    logic [W-1:0]  word_next;
    logic [AW-1:0] addr;
    logic          wr_valid;

    assign word_next = {word[W-9:0], i_rx_byte};  // First byte ends up on top

    // Word and address hold through the write cycle
    assign o_imem_wr.valid = wr_valid;
    assign o_imem_wr.addr  = addr;
    assign o_imem_wr.data  = word;

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            addr     <= '0;
            wr_valid <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            wr_valid <= 1'b0;
            o_done   <= 1'b0;
            if (wr_valid) begin
                addr <= addr + ADDR_STEP;  // Next word after each write
            end
            if (i_start) begin
                byte_cnt <= '0;
                addr     <= '0;
            end else if (i_rx_valid) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    if (word_next == END_WORD) begin
                        o_done <= 1'b1;  // Terminator is never written
                    end else begin
                        wr_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            word <= word_next;
        end
    end

endmodule

// ==== hw/state_dumper.sv ====
`include "debug_params.svh"

module state_dumper (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_start,
    input  logic [`DBG_WORD_BITS-1:0] i_pc,
    input  logic [`DBG_WORD_BITS-1:0] i_cycle_count,
    input  logic [`DBG_WORD_BITS-1:0] i_reg_data,
    input  logic [`DBG_WORD_BITS-1:0] i_mem_data,
    input  logic                      i_tx_ready,
    output debug_pkg::state_read_t    o_read,
    output debug_pkg::tx_byte_t       o_tx,
    output logic                      o_done
);

    localparam int W = `DBG_WORD_BITS;
    localparam int IDX_BITS = $clog2(`DBG_REG_COUNT);
    localparam logic [IDX_BITS-1:0] REG_LAST = IDX_BITS'(`DBG_REG_COUNT - 1);
    localparam logic [IDX_BITS-1:0] MEM_LAST = IDX_BITS'(`DBG_DMEM_WORDS - 1);

    typedef enum logic [1:0] {
        SEC_PC,
        SEC_CYCLE,
        SEC_REG,
        SEC_MEM
    } section_e;

    section_e            section;
    logic [IDX_BITS-1:0] index;
    logic                busy;
    logic                tx_valid;
    logic [1:0]          byte_cnt;
    logic [W-1:0]        shift;
    logic [W-1:0]        word_sel;
    logic                latch;
    logic                accept;
    logic                last_item;

    always_comb begin
        case (section)
            SEC_PC:    word_sel = i_pc;
            SEC_CYCLE: word_sel = i_cycle_count;
            SEC_REG:   word_sel = i_reg_data;
            default:   word_sel = i_mem_data;
        endcase
    end

    // One word in flight and latched while nothing is offered
    assign latch     = busy && !tx_valid;
    assign accept    = tx_valid && i_tx_ready;
    assign last_item = (section == SEC_MEM) && (index == MEM_LAST);

    assign o_read.reg_sel  = index;
    assign o_read.mem_addr = W'(index) << 2;  // Word index to byte address
    assign o_tx.valid      = tx_valid;
    assign o_tx.data       = shift[W-1 -: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            tx_valid <= 1'b0;
            byte_cnt <= '0;
            section  <= SEC_PC;
            index    <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start && !busy) begin
                busy    <= 1'b1;
                section <= SEC_PC;
                index   <= '0;
            end else if (latch) begin
                tx_valid <= 1'b1;
            end else if (accept) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    tx_valid <= 1'b0;
                    if (last_item) begin
                        busy   <= 1'b0;
                        o_done <= 1'b1;  // Lands with valid low
                    end else if (section == SEC_PC) begin
                        section <= SEC_CYCLE;
                    end else if (section == SEC_CYCLE) begin
                        section <= SEC_REG;
                    end else if (section == SEC_REG && index == REG_LAST) begin
                        section <= SEC_MEM;
                        index   <= '0;
                    end else begin
                        index <= index + 1'b1;
                    end
                end
            end
        end
    end

    // Shifts only on an accepted byte
    always_ff @(posedge clk) begin
        if (latch) begin
            shift <= word_sel;
        end else if (accept) begin
            shift <= shift << 8;
        end
    end

endmodule

// ==== sim/debug_unit_checker.sv ====
`include "debug_params.svh"

module debug_unit_checker (
    input logic                           clk,
    input logic                           reset,
    input logic                           i_rx_valid,
    input logic [7:0]                     i_rx_byte,
    input logic                           i_tx_ready,
    input logic                           o_tx_valid,
    input logic [7:0]                     o_tx_byte,
    input logic                           i_halt,
    input logic                           o_imem_wr_en,
    input logic [`DBG_IMEM_ADDR_BITS-1:0] o_imem_addr,
    input logic [`DBG_WORD_BITS-1:0]      o_imem_data,
    input logic                           o_target_clk_en,
    input logic                           o_target_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    import debug_pkg::*;

    localparam int DUMP_BYTES = 4 * (2 + `DBG_REG_COUNT + `DBG_DMEM_WORDS);

    int                             error_count = 0;
    int                             byte_idx;
    int                             word_idx;
    logic [31:0]                    rx_word;        // Last four received bytes in big-endian order
    logic [`DBG_IMEM_ADDR_BITS-1:0] exp_imem_addr;
    logic [31:0]                    enabled_cycles;
    logic [31:0]                    exp_word;
    logic [7:0]                     exp_byte;

    // Expected dump contents from the target model
    always_comb begin
        word_idx = byte_idx / 4;
        if (word_idx == 0) begin
            exp_word = 32'h0000_0040;
        end else if (word_idx == 1) begin
            exp_word = enabled_cycles;
        end else if (word_idx < 2 + `DBG_REG_COUNT) begin
            exp_word = 32'h1000_0000 + 32'(word_idx - 2);
        end else begin
            exp_word = 32'hA000_0000 + 32'((word_idx - 2 - `DBG_REG_COUNT) * 4);
        end
        exp_byte = exp_word[8*(3 - byte_idx % 4) +: 8];  // MSB first
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_imem_addr  <= '0;
            enabled_cycles <= '0;
            byte_idx       <= 0;
        end else begin
            if (i_rx_valid) begin
                rx_word <= {rx_word[23:0], i_rx_byte};
            end
            if (o_imem_wr_en) begin
                exp_imem_addr <= exp_imem_addr + 4;
            end
            if (o_target_reset) begin
                enabled_cycles <= '0;
            end else if (o_target_clk_en) begin
                enabled_cycles <= enabled_cycles + 1;
            end
            if (o_tx_valid && i_tx_ready) begin
                byte_idx <= (byte_idx == DUMP_BYTES - 1) ? 0 : byte_idx + 1;
            end
        end
    end

    a_reset_values: assert property (@(posedge clk) $fell(reset) |->
            !o_target_clk_en && !o_imem_wr_en && !o_tx_valid && o_target_reset)
        else begin
            error_count++;
            $error("Outputs not at their reset values");
        end

    a_imem_addr: assert property (@(posedge clk) disable iff (reset)
            o_imem_wr_en |-> o_imem_addr == exp_imem_addr)
        else begin
            error_count++;
            $error("** Error o_imem_addr got %h expected %h", o_imem_addr, exp_imem_addr);
        end

    a_imem_data: assert property (@(posedge clk) disable iff (reset)
            o_imem_wr_en |-> o_imem_data == rx_word && o_imem_data != '1)
        else begin
            error_count++;
            $error("** Error o_imem_data got %h expected %h", o_imem_data, rx_word);
        end

    a_run_until_halt: assert property (@(posedge clk) disable iff (reset)
            o_target_clk_en && !i_halt
            && !($rose(o_target_clk_en) && $past(i_rx_byte) == CMD_NEXT)
            |=> o_target_clk_en)
        else begin
            error_count++;
            $error("Clock enable dropped before halt");
        end

    a_halt_stops: assert property (@(posedge clk) disable iff (reset)
            o_target_clk_en && i_halt |=> !o_target_clk_en)
        else begin
            error_count++;
            $error("Clock enable still high after halt");
        end

    a_enable_cause: assert property (@(posedge clk) disable iff (reset)
            $rose(o_target_clk_en) |-> $past(i_rx_valid)
            && ($past(i_rx_byte) == CMD_RUN || $past(i_rx_byte) == CMD_NEXT))
        else begin
            error_count++;
            $error("Clock enable rose without a run or next command");
        end

    a_single_step: assert property (@(posedge clk) disable iff (reset)
            $rose(o_target_clk_en) && $past(i_rx_byte) == CMD_NEXT |=> !o_target_clk_en)
        else begin
            error_count++;
            $error("Step gave more than one enabled cycle");
        end

    a_dump_follows: assert property (@(posedge clk) disable iff (reset)
            $fell(o_target_clk_en) |-> byte_idx == 0 ##[1:3] o_tx_valid)
        else begin
            error_count++;
            $error("No complete dump after the target stopped");
        end

    a_dump_byte: assert property (@(posedge clk) disable iff (reset)
            o_tx_valid && i_tx_ready |-> o_tx_byte == exp_byte)
        else begin
            error_count++;
            $error("** Error o_tx_byte got %h expected %h", o_tx_byte, exp_byte);
        end

    a_tx_hold: assert property (@(posedge clk) disable iff (reset)
            o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_byte))
        else begin
            error_count++;
            $error("Transmit byte changed while stalled");
        end

    a_enable_in_reset: assert property (@(posedge clk) disable iff (reset)
            !(o_target_clk_en && o_target_reset))
        else begin
            error_count++;
            $error("Clock enable high while target held in reset");
        end

endmodule

// ==== sim/debug_unit_tb.sv ====
`include "debug_params.svh"

module debug_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import debug_pkg::*;

    localparam int PROG_WORDS = 6;
    localparam int TIMEOUT    = 5000;

    logic                              clk = 1'b0;
    logic                              reset;
    logic                              i_rx_valid;
    logic [7:0]                        i_rx_byte;
    logic                              i_tx_ready;
    logic                              o_tx_valid;
    logic [7:0]                        o_tx_byte;
    logic                              i_halt;
    logic [31:0]                       i_pc;
    logic [31:0]                       i_cycle_count;
    logic [31:0]                       i_reg_data;
    logic [31:0]                       i_mem_data;
    logic [$clog2(`DBG_REG_COUNT)-1:0] o_reg_sel;
    logic [31:0]                       o_mem_addr;
    logic                              o_imem_wr_en;
    logic [`DBG_IMEM_ADDR_BITS-1:0]    o_imem_addr;
    logic [31:0]                       o_imem_data;
    logic                              o_target_clk_en;
    logic                              o_target_reset;

    logic [31:0] lfsr = 32'hf85b_f2fe;
    logic [31:0] program_words[PROG_WORDS];
    logic [31:0] rand_val;
    int          tx_accepted = 0;
    int          imem_writes = 0;
    int          timeouts = 0;

    debug_unit_top i_debug_unit_top (.*);

    bind debug_unit_top debug_unit_checker i_checker (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Target model that counts enabled cycles
    assign i_pc       = 32'h0000_0040;
    assign i_reg_data = 32'h1000_0000 + 32'(o_reg_sel);
    assign i_mem_data = 32'hA000_0000 + o_mem_addr;
    assign i_halt     = i_cycle_count >= 20;

    always @(negedge clk) begin
        if (o_target_reset) begin
            i_cycle_count <= '0;
        end else if (o_target_clk_en) begin
            i_cycle_count <= i_cycle_count + 1;
        end
        take_bits(2, rand_val);
        i_tx_ready <= rand_val[1:0] != 2'b00;  // Ready gaps
    end

    always @(posedge clk) begin
        if (o_tx_valid && i_tx_ready) tx_accepted++;
        if (o_imem_wr_en) imem_writes++;
    end

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        i_rx_valid = 1'b1;
        i_rx_byte  = b;
        @(negedge clk);
        i_rx_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_tx_bytes(input int target, input string what);
        int n;
        n = 0;
        while (tx_accepted < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx_accepted < target) begin
            $display("Timeout waiting for the dump after %s", what);
            timeouts++;
        end
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        while (imem_writes < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (imem_writes < target) begin
            $display("Timeout waiting for the program writes");
            timeouts++;
        end
    endtask

    task automatic wait_target_reset();
        int n;
        n = 0;
        while (!o_target_reset && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!o_target_reset) begin
            $display("Timeout waiting for the unit to return to idle");
            timeouts++;
        end
    endtask

    initial begin
        reset         = 1'b1;
        i_rx_valid    = 1'b0;
        i_rx_byte     = 8'h00;
        i_tx_ready    = 1'b0;
        i_cycle_count = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            take_bits(32, program_words[i]);
            if (program_words[i] == '1) program_words[i][0] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        send_byte(CMD_LOAD);
        for (int i = 0; i < PROG_WORDS; i++) begin
            for (int b = 3; b >= 0; b--) send_byte(program_words[i][8*b +: 8]);
        end
        for (int b = 0; b < 4; b++) send_byte(8'hff);
        wait_writes(PROG_WORDS);
        repeat (3) @(negedge clk);

        send_byte(CMD_RUN);
        wait_tx_bytes(200, "run");
        wait_target_reset();

        send_byte(CMD_STEP);
        send_byte(8'h78);  // Not a step command
        send_byte(CMD_NEXT);
        wait_tx_bytes(400, "first step");
        send_byte(CMD_NEXT);
        wait_tx_bytes(600, "second step");
        repeat (5) @(negedge clk);

        $display("Done: %0d assertion errors, %0d timeouts",
                 i_debug_unit_top.i_checker.error_count, timeouts);
        if (i_debug_unit_top.i_checker.error_count == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
